/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, then judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_eeprom_if \
    -Mdir obj_dir -o sim > build.log 2>&1 \
    && ./obj_dir/sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "no pass line in log"; exit 1; }
exit 0

/* test/eeprom_model.sv */
`timescale 1ns/100ps

module eeprom_model
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        scl,
    input  logic        sda,
    input  logic        nack_all,       // refuse every byte
    output logic        sda_pull,
    output logic [3:0]  frame_rises,    // scl rises since the last byte boundary
    output logic [15:0] starts,
    output logic [15:0] stops,
    output logic [15:0] writes_done
);
    import eeprom_pkg::*;

    typedef enum logic [2:0]
    {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA,
        M_TX,
        M_WAIT
    } model_state_e;

    model_state_e mode;
    model_state_e mode_next;    // taken at the end of the ack slot
    logic [7:0]   mem [0:2047];
    logic [10:0]  ptr;
    logic [7:0]   shreg;
    logic [7:0]   tx_sh;
    logic [3:0]   bit_cnt;
    logic         scl_q;
    logic         sda_q;
    logic         skip_fall;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'h5a ^ {3'(i >> 8), 5'b0};
    end

    // bus levels are seen one clk late, which keeps the model edge driven
    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            mode        <= M_IDLE;
            mode_next   <= M_IDLE;
            sda_pull    <= 1'b0;
            frame_rises <= 4'd0;
            bit_cnt     <= 4'd0;
            skip_fall   <= 1'b0;
            starts      <= 16'd0;
            stops       <= 16'd0;
            writes_done <= 16'd0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda != sda_q)
            begin
                frame_rises <= 4'd0;
                sda_pull    <= 1'b0;
                if (!sda)
                begin
                    starts    <= starts + 16'd1;
                    mode      <= M_CTRL;
                    bit_cnt   <= 4'd0;
                    skip_fall <= 1'b1;  // scl falls right after the start
                end
                else
                begin
                    stops <= stops + 16'd1;
                    mode  <= M_IDLE;
                end
            end
            else if (scl && !scl_q)
            begin
                frame_rises <= frame_rises + 4'd1;
                if (bit_cnt < 4'd8)
                    shreg <= {shreg[6:0], sda};
            end
            else if (!scl && scl_q)
            begin
                if (skip_fall)
                    skip_fall <= 1'b0;
                else if (mode != M_IDLE)
                begin
                    if (bit_cnt == 4'd7)
                    begin
                        bit_cnt   <= 4'd8;
                        sda_pull  <= 1'b0;
                        mode_next <= M_WAIT;
                        if (!nack_all)
                        begin
                            case (mode)
                                M_CTRL:
                                    if (shreg[7:4] == DEV_TYPE)
                                    begin
                                        ptr[10:8] <= shreg[3:1];
                                        mode_next <= shreg[0] ? M_TX : M_ADDR;
                                        sda_pull  <= 1'b1;
                                    end
                                M_ADDR:
                                begin
                                    ptr[7:0]  <= shreg;
                                    mode_next <= M_DATA;
                                    sda_pull  <= 1'b1;
                                end
                                M_DATA:
                                begin
                                    mem[ptr]    <= shreg;
                                    writes_done <= writes_done + 16'd1;
                                    sda_pull    <= 1'b1;
                                end
                                default:
                                    sda_pull <= 1'b0;
                            endcase
                        end
                    end
                    else if (bit_cnt == 4'd8)
                    begin
                        bit_cnt     <= 4'd0;
                        frame_rises <= 4'd0;
                        mode        <= mode_next;
                        sda_pull    <= 1'b0;
                        if (mode_next == M_TX)
                        begin
                            tx_sh    <= mem[ptr];
                            sda_pull <= !mem[ptr][7];   // msb first
                        end
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (mode == M_TX)
                            sda_pull <= !tx_sh[3'(6 - int'(bit_cnt))];
                    end
                end
            end
        end
    end

endmodule

/* test/tb_eeprom_if.sv */
`timescale 1ns/100ps

module tb_eeprom_if;
    import eeprom_pkg::*;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        data_in;
    logic [7:0]        data_out;
    logic              ack;
    logic              ack_error;
    logic              busy;
    logic              scl;
    logic              sda_oe;
    logic              sda;
    logic              sda_pull;
    logic              nack_all;
    logic [3:0]        frame_rises;
    logic [15:0]       starts;
    logic [15:0]       stops;
    logic [15:0]       writes_done;
    logic [7:0]        ref_mem [0:2047];
    logic              written [0:2047];
    logic [7:0]        rdata;
    logic [ADDR_W-1:0] a;
    integer            seed;
    int                chk_errors;
    int                prop_errors = 0;
    int                ack_count = 0;
    int                exp_starts;
    int                exp_stops;
    int                exp_writes;

    always #50 CLK = !CLK;

    assign sda = !(sda_oe || sda_pull);     // pull-up on the bus

    eeprom_if i_eeprom_if
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .data_in   (data_in),
        .data_out  (data_out),
        .ack       (ack),
        .ack_error (ack_error),
        .busy      (busy),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda)
    );

    eeprom_model i_eeprom_model
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .scl         (scl),
        .sda         (sda),
        .nack_all    (nack_all),
        .sda_pull    (sda_pull),
        .frame_rises (frame_rises),
        .starts      (starts),
        .stops       (stops),
        .writes_done (writes_done)
    );

    always @(posedge CLK)
    begin
        if (ack)
            ack_count <= ack_count + 1;
    end

    // inside a byte sda may only move while scl is low
    a_bus_protocol: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda != $past(sda)) |-> frame_rises <= 4'd1)
        else
        begin
            prop_errors++;
            $display("sda changed while scl was high inside a byte at %0t", $time);
        end

    // an idle sequencer leaves the bus free
    a_idle_bus: assert property (@(posedge CLK) disable iff (RESET)
        i_eeprom_if.i_eeprom_ctrl.state == IDLE |-> scl && sda)
        else
        begin
            prop_errors++;
            $display("bus not free while the controller was idle at %0t", $time);
        end

    task automatic compare(input string name, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            chk_errors++;
            $display("error: %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // one request, optionally with ignored strobes while busy
    task automatic request(input string name, input logic is_write, input logic [10:0] ra,
                           input logic [7:0] d, input logic exp_err, input logic noise,
                           output logic [7:0] rd_val);
        int acks_before;
        int n;
        acks_before = ack_count;
        @(negedge CLK);
        wr      = is_write;
        rd      = !is_write;
        addr    = ra;
        data_in = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        for (int k = 0; k < 4 && noise; k++)
        begin
            @(negedge CLK);
            wr      = busy && k[0];
            rd      = busy && !k[0];
            addr    = 11'($random(seed));
            data_in = 8'($random(seed));
            @(negedge CLK);
            wr = 1'b0;
            rd = 1'b0;
        end
        n = 0;
        while (!ack && n < MAX_XFER_CYCLES)
        begin
            @(negedge CLK);
            n++;
        end
        if (!ack)
        begin
            chk_errors++;
            $display("timeout: %s got no ack within %0d cycles", name, MAX_XFER_CYCLES);
        end
        compare({name, " ack_error"}, int'(exp_err), int'(ack_error));
        rd_val = data_out;
        n = 0;
        @(negedge CLK);
        while (busy && n < 8)
        begin
            @(negedge CLK);
            n++;
        end
        if (busy)
        begin
            chk_errors++;
            $display("timeout: %s left the controller busy", name);
        end
        compare({name, " ack count"}, acks_before + 1, ack_count);
        exp_stops++;
        exp_starts += (is_write || exp_err) ? 1 : 2;
    endtask

    task automatic write_byte(input string name, input logic [10:0] wa, input logic [7:0] d,
                              input logic noise);
        logic [7:0] unused;
        request(name, 1'b1, wa, d, 1'b0, noise, unused);
        ref_mem[wa] = d;
        written[wa] = 1'b1;
        exp_writes++;
    endtask

    task automatic read_check(input string name, input logic [10:0] ra);
        logic [7:0] got;
        request(name, 1'b0, ra, 8'h00, 1'b0, 1'b0, got);
        compare({name, " data"}, int'(ref_mem[ra]), int'(got));
    endtask

    initial
    begin
        seed       = 32'h52fd;
        CLK        = 1'b0;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        data_in    = 8'h00;
        nack_all   = 1'b0;
        chk_errors = 0;
        exp_starts = 0;
        exp_stops  = 0;
        exp_writes = 0;
        for (int i = 0; i < 2048; i++)
        begin
            ref_mem[i] = 8'(i) ^ 8'h5a ^ {3'(i >> 8), 5'b0};
            written[i] = 1'b0;
        end
        repeat (16) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        compare("reset scl", 1, int'(scl));
        compare("reset sda_oe", 0, int'(sda_oe));
        compare("reset busy", 0, int'(busy));
        compare("reset ack", 0, int'(ack));

        repeat (4)
        begin
            a = 11'($random(seed));
            write_byte("write", a, 8'($random(seed)), 1'b0);
            read_check("read back", a);
        end

        // one read per value of the upper address bits
        for (int u = 0; u < 8; u++)
        begin
            a = {3'(u), 8'($random(seed))};
            while (written[a])
                a[7:0] = a[7:0] + 8'd1;
            read_check("init read", a);
        end

        a = 11'($random(seed));
        write_byte("busy strobes", a, 8'($random(seed)), 1'b1);
        read_check("busy strobes read", a);

        @(negedge CLK);
        nack_all = 1'b1;
        request("nack write", 1'b1, 11'($random(seed)), 8'hc3, 1'b1, 1'b0, rdata);
        @(negedge CLK);
        nack_all = 1'b0;
        a = 11'($random(seed));
        write_byte("after nack", a, 8'($random(seed)), 1'b0);
        read_check("after nack read", a);

        compare("start count", exp_starts, int'(starts));
        compare("stop count", exp_stops, int'(stops));
        compare("model writes", exp_writes, int'(writes_done));

        $display("errors: checks %0d, protocol %0d", chk_errors, prop_errors);
        if (chk_errors == 0 && prop_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* verilog.f */
verilog/eeprom_pkg.sv
verilog/eeprom_bit_engine.sv
verilog/eeprom_ctrl.sv
verilog/eeprom_if.sv
test/eeprom_model.sv
test/tb_eeprom_if.sv

/* verilog/eeprom_bit_engine.sv */
`timescale 1ns/100ps

module eeprom_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  eeprom_pkg::bit_cmd_e cmd,
    input  logic [7:0]           tx_byte,
    input  logic                 tx_nack,
    input  logic                 sda_in,
    output logic                 done,
    output logic [7:0]           rx_byte,
    output logic                 rx_ack_bad,
    output logic                 scl,
    output logic                 sda_oe
);
    import eeprom_pkg::*;

    logic       active;
    bit_cmd_e   op;
    logic [1:0] phase;      // quarter of the current bit
    logic [3:0] bit_cnt;    // 0..7 data, 8 is the ack slot
    logic [7:0] tx_q;
    logic       nack_q;
    logic       last_step;
    bit_cmd_e   op_nxt;
    logic [1:0] phase_nxt;
    logic [3:0] bit_nxt;
    logic [7:0] tx_nxt;
    logic       nack_nxt;
    logic       scl_nxt;
    logic       sda_nxt;

    // final quarter of the final bit
    assign last_step = active && phase == 2'(PHASES_PER_BIT - 1)
                       && (op == CMD_START || op == CMD_STOP || bit_cnt == 4'd8);

    // line levels for the quarter that is entered next
    always_comb
    begin
        op_nxt    = cmd_valid ? cmd : op;
        tx_nxt    = cmd_valid ? tx_byte : tx_q;
        nack_nxt  = cmd_valid ? tx_nack : nack_q;
        phase_nxt = cmd_valid ? 2'd0 : phase + 2'd1;
        bit_nxt   = bit_cnt;
        if (cmd_valid)
            bit_nxt = 4'd0;
        else if (phase == 2'(PHASES_PER_BIT - 1))
            bit_nxt = bit_cnt + 4'd1;

        case (op_nxt)
            CMD_START:
            begin
                scl_nxt = phase_nxt[0] ^ phase_nxt[1];
                sda_nxt = phase_nxt[1];     // pulled low with scl high
            end
            CMD_STOP:
            begin
                scl_nxt = phase_nxt != 2'd0;    // left high for idle bus
                sda_nxt = !phase_nxt[1];        // released with scl high
            end
            CMD_WRITE:
            begin
                scl_nxt = phase_nxt[0] ^ phase_nxt[1];
                if (bit_nxt == 4'd8)
                    sda_nxt = 1'b0;     // let the slave ack
                else
                    sda_nxt = !tx_nxt[3'd7 - bit_nxt[2:0]];
            end
            default:
            begin
                scl_nxt = phase_nxt[0] ^ phase_nxt[1];
                if (bit_nxt == 4'd8)
                    sda_nxt = !nack_nxt;
                else
                    sda_nxt = 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active     <= 1'b0;
            op         <= CMD_START;
            phase      <= 2'd0;
            bit_cnt    <= 4'd0;
            done       <= 1'b0;
            rx_ack_bad <= 1'b0;
            scl        <= 1'b1;
            sda_oe     <= 1'b0;
        end
        else
        begin
            done <= last_step;
            // lines hold their last level between commands
            if (cmd_valid || (active && !last_step))
            begin
                op      <= op_nxt;
                phase   <= phase_nxt;
                bit_cnt <= bit_nxt;
                scl     <= scl_nxt;
                sda_oe  <= sda_nxt;
            end
            if (cmd_valid)
            begin
                active     <= 1'b1;
                rx_ack_bad <= 1'b0;
            end
            else if (last_step)
                active <= 1'b0;
            if (active && op == CMD_WRITE && bit_cnt == 4'd8 && phase == 2'd1)
                rx_ack_bad <= sda_in;   // high means no ack
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_valid)
        begin
            tx_q   <= tx_byte;
            nack_q <= tx_nack;
        end
        if (active && op == CMD_READ && bit_cnt < 4'd8 && phase == 2'd1)
            rx_byte <= {rx_byte[6:0], sda_in};  // msb first
    end

    // only start and stop may move sda while scl is high
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda_oe != $past(sda_oe))
        |-> (op == CMD_START || op == CMD_STOP));

    a_no_overlap: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> !active);

endmodule

/* verilog/eeprom_ctrl.sv */
`timescale 1ns/100ps

module eeprom_ctrl
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    data_in,
    output logic [7:0]                    data_out,
    output logic                          ack,
    output logic                          ack_error,
    output logic                          busy,
    output logic                          cmd_valid,
    output eeprom_pkg::bit_cmd_e          cmd,
    output logic [7:0]                    tx_byte,
    output logic                          tx_nack,
    input  logic                          done,
    input  logic [7:0]                    rx_byte,
    input  logic                          rx_ack_bad
);
    import eeprom_pkg::*;

    ctrl_state_e       state;
    ctrl_state_e       state_nxt;
    logic              is_rd;
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        data_q;
    logic              pending;     // command sent, engine not done yet
    logic              step;
    logic              issue;
    logic              accept;

    assign accept = state == IDLE && (wr || rd);
    assign step   = done && pending;
    assign busy   = state != IDLE;

    // every state change except into DONE or IDLE starts an engine command
    assign issue  = state_nxt != state && state_nxt != DONE && state_nxt != IDLE;

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
                if (accept)
                    state_nxt = START;
            START:
                if (step)
                    state_nxt = CTRL_WR;
            CTRL_WR:
                if (step)
                    state_nxt = rx_ack_bad ? STOP : ADDR;
            ADDR:
                if (step)
                begin
                    if (rx_ack_bad)
                        state_nxt = STOP;
                    else
                        state_nxt = is_rd ? RESTART : DATA_WR;
                end
            DATA_WR:
                if (step)
                    state_nxt = STOP;
            RESTART:
                if (step)
                    state_nxt = CTRL_RD;
            CTRL_RD:
                if (step)
                    state_nxt = rx_ack_bad ? STOP : DATA_RD;
            DATA_RD:
                if (step)
                    state_nxt = STOP;
            STOP:
                if (step)
                    state_nxt = DONE;
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            is_rd     <= 1'b0;
            pending   <= 1'b0;
            cmd_valid <= 1'b0;
            ack       <= 1'b0;
            ack_error <= 1'b0;
        end
        else
        begin
            state     <= state_nxt;
            cmd_valid <= issue;
            ack       <= state_nxt == DONE;
            if (cmd_valid)
                pending <= 1'b1;
            else if (done)
                pending <= 1'b0;
            if (accept)
            begin
                is_rd     <= !wr;   // wr wins
                ack_error <= 1'b0;
            end
            else if (step)
                ack_error <= ack_error | rx_ack_bad;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q <= addr;
            data_q <= data_in;
        end
        if (issue)
        begin
            tx_nack <= state_nxt == DATA_RD;    // single byte read ends with nack
            case (state_nxt)
                START, RESTART: cmd <= CMD_START;
                STOP:           cmd <= CMD_STOP;
                DATA_RD:        cmd <= CMD_READ;
                default:        cmd <= CMD_WRITE;
            endcase
            case (state_nxt)
                CTRL_WR: tx_byte <= {DEV_TYPE, addr_q[ADDR_W-1:8], 1'b0};
                CTRL_RD: tx_byte <= {DEV_TYPE, addr_q[ADDR_W-1:8], 1'b1};
                ADDR:    tx_byte <= addr_q[7:0];
                default: tx_byte <= data_q;
            endcase
        end
        if (state == DATA_RD && step)
            data_out <= rx_byte;
    end

    a_ack_single: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack);

    // one command in flight at a time
    a_no_cmd_pending: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> !pending);

endmodule

/* verilog/eeprom_if.sv */
`timescale 1ns/100ps

module eeprom_if
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    data_in,
    output logic [7:0]                    data_out,
    output logic                          ack,
    output logic                          ack_error,
    output logic                          busy,
    output logic                          scl,
    output logic                          sda_oe,
    input  logic                          sda_in
);
    import eeprom_pkg::*;

    logic       cmd_valid;
    bit_cmd_e   cmd;
    logic [7:0] tx_byte;
    logic       tx_nack;
    logic       done;
    logic [7:0] rx_byte;
    logic       rx_ack_bad;

    eeprom_ctrl i_eeprom_ctrl
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .data_in    (data_in),
        .data_out   (data_out),
        .ack        (ack),
        .ack_error  (ack_error),
        .busy       (busy),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .tx_byte    (tx_byte),
        .tx_nack    (tx_nack),
        .done       (done),
        .rx_byte    (rx_byte),
        .rx_ack_bad (rx_ack_bad)
    );

    eeprom_bit_engine i_eeprom_bit_engine
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .tx_byte    (tx_byte),
        .tx_nack    (tx_nack),
        .sda_in     (sda_in),
        .done       (done),
        .rx_byte    (rx_byte),
        .rx_ack_bad (rx_ack_bad),
        .scl        (scl),
        .sda_oe     (sda_oe)
    );

endmodule

/* verilog/eeprom_pkg.sv */
package eeprom_pkg;

    // commands from the sequencer to the bit engine
    typedef enum logic [1:0]
    {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bit_cmd_e;

    // sequencer states
    typedef enum logic [3:0]
    {
        IDLE,
        START,
        CTRL_WR,
        ADDR,
        DATA_WR,
        RESTART,
        CTRL_RD,
        DATA_RD,
        STOP,
        DONE
    } ctrl_state_e;

    localparam int PHASES_PER_BIT = 4;          // clk cycles per scl period

    localparam logic [3:0] DEV_TYPE = 4'b1010;  // top nibble of control byte

    localparam int ADDR_W = 11;                 // 2 KB array

    // a random read needs roughly 200 cycles, so this leaves ample margin
    localparam int MAX_XFER_CYCLES = 150 * PHASES_PER_BIT;

endpackage
